//--- Makefile
# Verilator build and run of the AXI cut testbench

TOP := tb_axi_cut_mem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module $(TOP) -f flist.f -Mdir obj_dir -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

//--- axi_cfg_pkg.sv
// #####################################################################
// Bus and memory sizes of the AXI cut and memory slave
//   Address, data, strobe and ID widths
//   Memory depth in words
//   Packed widths of the five channel payloads
// #####################################################################

package axi_cfg_pkg;

  localparam int AddrWidth = 16;
  localparam int DataWidth = 32;
  localparam int StrbWidth = DataWidth / 8;
  localparam int IdWidth   = 4;

  // 256 words, byte addresses 0 to 1023
  localparam int MemWords  = 256;

  // Channel payloads as packed for the spill registers
  // AW and AR: id, addr, len, burst
  localparam int AwWidth = IdWidth + AddrWidth + axi_proto_pkg::LenWidth + 2;
  // W: data, strb, last
  localparam int WWidth  = DataWidth + StrbWidth + 1;
  // B: id, resp
  localparam int BWidth  = IdWidth + 2;
  localparam int ArWidth = AwWidth;
  // R: id, data, resp, last
  localparam int RWidth  = IdWidth + DataWidth + 2 + 1;

endpackage

//--- axi_cut.sv
// #####################################################################
// AXI4 register cut
//   One spill register per channel (AW, W, B, AR, R)
//   Channel fields packed into one vector per register
// #####################################################################

module axi_cut #(
  parameter bit Bypass = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Slave port
  input  logic [axi_cfg_pkg::IdWidth-1:0]     s_aw_id_i,
  input  logic [axi_cfg_pkg::AddrWidth-1:0]   s_aw_addr_i,
  input  logic [axi_proto_pkg::LenWidth-1:0]  s_aw_len_i,
  input  logic [1:0]                          s_aw_burst_i,
  input  logic                                s_aw_valid_i,
  output logic                                s_aw_ready_o,
  input  logic [axi_cfg_pkg::DataWidth-1:0]   s_w_data_i,
  input  logic [axi_cfg_pkg::StrbWidth-1:0]   s_w_strb_i,
  input  logic                                s_w_last_i,
  input  logic                                s_w_valid_i,
  output logic                                s_w_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     s_b_id_o,
  output logic [1:0]                          s_b_resp_o,
  output logic                                s_b_valid_o,
  input  logic                                s_b_ready_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     s_ar_id_i,
  input  logic [axi_cfg_pkg::AddrWidth-1:0]   s_ar_addr_i,
  input  logic [axi_proto_pkg::LenWidth-1:0]  s_ar_len_i,
  input  logic [1:0]                          s_ar_burst_i,
  input  logic                                s_ar_valid_i,
  output logic                                s_ar_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     s_r_id_o,
  output logic [axi_cfg_pkg::DataWidth-1:0]   s_r_data_o,
  output logic [1:0]                          s_r_resp_o,
  output logic                                s_r_last_o,
  output logic                                s_r_valid_o,
  input  logic                                s_r_ready_i,
  // Master port
  output logic [axi_cfg_pkg::IdWidth-1:0]     m_aw_id_o,
  output logic [axi_cfg_pkg::AddrWidth-1:0]   m_aw_addr_o,
  output logic [axi_proto_pkg::LenWidth-1:0]  m_aw_len_o,
  output logic [1:0]                          m_aw_burst_o,
  output logic                                m_aw_valid_o,
  input  logic                                m_aw_ready_i,
  output logic [axi_cfg_pkg::DataWidth-1:0]   m_w_data_o,
  output logic [axi_cfg_pkg::StrbWidth-1:0]   m_w_strb_o,
  output logic                                m_w_last_o,
  output logic                                m_w_valid_o,
  input  logic                                m_w_ready_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     m_b_id_i,
  input  logic [1:0]                          m_b_resp_i,
  input  logic                                m_b_valid_i,
  output logic                                m_b_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     m_ar_id_o,
  output logic [axi_cfg_pkg::AddrWidth-1:0]   m_ar_addr_o,
  output logic [axi_proto_pkg::LenWidth-1:0]  m_ar_len_o,
  output logic [1:0]                          m_ar_burst_o,
  output logic                                m_ar_valid_o,
  input  logic                                m_ar_ready_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     m_r_id_i,
  input  logic [axi_cfg_pkg::DataWidth-1:0]   m_r_data_i,
  input  logic [1:0]                          m_r_resp_i,
  input  logic                                m_r_last_i,
  input  logic                                m_r_valid_i,
  output logic                                m_r_ready_o
);

  logic [axi_cfg_pkg::AwWidth-1:0] aw_in, aw_out;
  logic [axi_cfg_pkg::WWidth-1:0]  w_in, w_out;
  logic [axi_cfg_pkg::BWidth-1:0]  b_in, b_out;
  logic [axi_cfg_pkg::ArWidth-1:0] ar_in, ar_out;
  logic [axi_cfg_pkg::RWidth-1:0]  r_in, r_out;

  // Requests flow slave to master
  assign aw_in = {s_aw_id_i, s_aw_addr_i, s_aw_len_i, s_aw_burst_i};
  assign {m_aw_id_o, m_aw_addr_o, m_aw_len_o, m_aw_burst_o} = aw_out;
  assign w_in  = {s_w_data_i, s_w_strb_i, s_w_last_i};
  assign {m_w_data_o, m_w_strb_o, m_w_last_o} = w_out;
  assign ar_in = {s_ar_id_i, s_ar_addr_i, s_ar_len_i, s_ar_burst_i};
  assign {m_ar_id_o, m_ar_addr_o, m_ar_len_o, m_ar_burst_o} = ar_out;

  // Responses flow master to slave
  assign b_in  = {m_b_id_i, m_b_resp_i};
  assign {s_b_id_o, s_b_resp_o} = b_out;
  assign r_in  = {m_r_id_i, m_r_data_i, m_r_resp_i, m_r_last_i};
  assign {s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o} = r_out;

  spill_register #(.Width(axi_cfg_pkg::AwWidth), .Bypass(Bypass)) u_reg_aw (
    .clk_i   (clk_i),        .rst_i   (rst_i),
    .valid_i (s_aw_valid_i), .ready_o (s_aw_ready_o), .data_i (aw_in),
    .valid_o (m_aw_valid_o), .ready_i (m_aw_ready_i), .data_o (aw_out)
  );

  spill_register #(.Width(axi_cfg_pkg::WWidth), .Bypass(Bypass)) u_reg_w (
    .clk_i   (clk_i),       .rst_i   (rst_i),
    .valid_i (s_w_valid_i), .ready_o (s_w_ready_o), .data_i (w_in),
    .valid_o (m_w_valid_o), .ready_i (m_w_ready_i), .data_o (w_out)
  );

  spill_register #(.Width(axi_cfg_pkg::BWidth), .Bypass(Bypass)) u_reg_b (
    .clk_i   (clk_i),       .rst_i   (rst_i),
    .valid_i (m_b_valid_i), .ready_o (m_b_ready_o), .data_i (b_in),
    .valid_o (s_b_valid_o), .ready_i (s_b_ready_i), .data_o (b_out)
  );

  spill_register #(.Width(axi_cfg_pkg::ArWidth), .Bypass(Bypass)) u_reg_ar (
    .clk_i   (clk_i),        .rst_i   (rst_i),
    .valid_i (s_ar_valid_i), .ready_o (s_ar_ready_o), .data_i (ar_in),
    .valid_o (m_ar_valid_o), .ready_i (m_ar_ready_i), .data_o (ar_out)
  );

  spill_register #(.Width(axi_cfg_pkg::RWidth), .Bypass(Bypass)) u_reg_r (
    .clk_i   (clk_i),       .rst_i   (rst_i),
    .valid_i (m_r_valid_i), .ready_o (m_r_ready_o), .data_i (r_in),
    .valid_o (s_r_valid_o), .ready_i (s_r_ready_i), .data_o (r_out)
  );

endmodule

//--- axi_cut_mem_top.sv
// #####################################################################
// Top level: outside AXI4 port, register cut, memory slave
// #####################################################################

module axi_cut_mem_top #(
  parameter bit Bypass = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     s_aw_id_i,
  input  logic [axi_cfg_pkg::AddrWidth-1:0]   s_aw_addr_i,
  input  logic [axi_proto_pkg::LenWidth-1:0]  s_aw_len_i,
  input  logic [1:0]                          s_aw_burst_i,
  input  logic                                s_aw_valid_i,
  output logic                                s_aw_ready_o,
  input  logic [axi_cfg_pkg::DataWidth-1:0]   s_w_data_i,
  input  logic [axi_cfg_pkg::StrbWidth-1:0]   s_w_strb_i,
  input  logic                                s_w_last_i,
  input  logic                                s_w_valid_i,
  output logic                                s_w_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     s_b_id_o,
  output logic [1:0]                          s_b_resp_o,
  output logic                                s_b_valid_o,
  input  logic                                s_b_ready_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     s_ar_id_i,
  input  logic [axi_cfg_pkg::AddrWidth-1:0]   s_ar_addr_i,
  input  logic [axi_proto_pkg::LenWidth-1:0]  s_ar_len_i,
  input  logic [1:0]                          s_ar_burst_i,
  input  logic                                s_ar_valid_i,
  output logic                                s_ar_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     s_r_id_o,
  output logic [axi_cfg_pkg::DataWidth-1:0]   s_r_data_o,
  output logic [1:0]                          s_r_resp_o,
  output logic                                s_r_last_o,
  output logic                                s_r_valid_o,
  input  logic                                s_r_ready_i
);

  // Internal bus between cut and memory
  logic [axi_cfg_pkg::IdWidth-1:0]    m_aw_id, m_b_id, m_ar_id, m_r_id;
  logic [axi_cfg_pkg::AddrWidth-1:0]  m_aw_addr, m_ar_addr;
  logic [axi_proto_pkg::LenWidth-1:0] m_aw_len, m_ar_len;
  logic [1:0]                         m_aw_burst, m_ar_burst, m_b_resp, m_r_resp;
  logic [axi_cfg_pkg::DataWidth-1:0]  m_w_data, m_r_data;
  logic [axi_cfg_pkg::StrbWidth-1:0]  m_w_strb;
  logic                               m_w_last, m_r_last;
  logic                               m_aw_valid, m_w_valid, m_b_valid, m_ar_valid, m_r_valid;
  logic                               m_aw_ready, m_w_ready, m_b_ready, m_ar_ready, m_r_ready;

  axi_cut #(.Bypass(Bypass)) u_cut (
    .clk_i, .rst_i,
    .s_aw_id_i, .s_aw_addr_i, .s_aw_len_i, .s_aw_burst_i, .s_aw_valid_i, .s_aw_ready_o,
    .s_w_data_i, .s_w_strb_i, .s_w_last_i, .s_w_valid_i, .s_w_ready_o,
    .s_b_id_o, .s_b_resp_o, .s_b_valid_o, .s_b_ready_i,
    .s_ar_id_i, .s_ar_addr_i, .s_ar_len_i, .s_ar_burst_i, .s_ar_valid_i, .s_ar_ready_o,
    .s_r_id_o, .s_r_data_o, .s_r_resp_o, .s_r_last_o, .s_r_valid_o, .s_r_ready_i,
    .m_aw_id_o (m_aw_id), .m_aw_addr_o (m_aw_addr), .m_aw_len_o (m_aw_len),
    .m_aw_burst_o (m_aw_burst), .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready),
    .m_w_data_o (m_w_data), .m_w_strb_o (m_w_strb), .m_w_last_o (m_w_last),
    .m_w_valid_o (m_w_valid), .m_w_ready_i (m_w_ready),
    .m_b_id_i (m_b_id), .m_b_resp_i (m_b_resp), .m_b_valid_i (m_b_valid),
    .m_b_ready_o (m_b_ready),
    .m_ar_id_o (m_ar_id), .m_ar_addr_o (m_ar_addr), .m_ar_len_o (m_ar_len),
    .m_ar_burst_o (m_ar_burst), .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready),
    .m_r_id_i (m_r_id), .m_r_data_i (m_r_data), .m_r_resp_i (m_r_resp),
    .m_r_last_i (m_r_last), .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready)
  );

  axi_mem_slave u_mem (
    .clk_i, .rst_i,
    .s_aw_id_i (m_aw_id), .s_aw_addr_i (m_aw_addr), .s_aw_len_i (m_aw_len),
    .s_aw_burst_i (m_aw_burst), .s_aw_valid_i (m_aw_valid), .s_aw_ready_o (m_aw_ready),
    .s_w_data_i (m_w_data), .s_w_strb_i (m_w_strb), .s_w_last_i (m_w_last),
    .s_w_valid_i (m_w_valid), .s_w_ready_o (m_w_ready),
    .s_b_id_o (m_b_id), .s_b_resp_o (m_b_resp), .s_b_valid_o (m_b_valid),
    .s_b_ready_i (m_b_ready),
    .s_ar_id_i (m_ar_id), .s_ar_addr_i (m_ar_addr), .s_ar_len_i (m_ar_len),
    .s_ar_burst_i (m_ar_burst), .s_ar_valid_i (m_ar_valid), .s_ar_ready_o (m_ar_ready),
    .s_r_id_o (m_r_id), .s_r_data_o (m_r_data), .s_r_resp_o (m_r_resp),
    .s_r_last_o (m_r_last), .s_r_valid_o (m_r_valid), .s_r_ready_i (m_r_ready)
  );

endmodule

//--- axi_mem_slave.sv
// #####################################################################
// AXI4 memory slave
//   Independent write and read FSMs, one burst at a time each
//   FIXED and INCR address generation, byte strobes
//   SLVERR for WRAP bursts, DECERR beyond the memory range
// #####################################################################

module axi_mem_slave (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     s_aw_id_i,
  input  logic [axi_cfg_pkg::AddrWidth-1:0]   s_aw_addr_i,
  input  logic [axi_proto_pkg::LenWidth-1:0]  s_aw_len_i,
  input  logic [1:0]                          s_aw_burst_i,
  input  logic                                s_aw_valid_i,
  output logic                                s_aw_ready_o,
  input  logic [axi_cfg_pkg::DataWidth-1:0]   s_w_data_i,
  input  logic [axi_cfg_pkg::StrbWidth-1:0]   s_w_strb_i,
  input  logic                                s_w_last_i,
  input  logic                                s_w_valid_i,
  output logic                                s_w_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     s_b_id_o,
  output logic [1:0]                          s_b_resp_o,
  output logic                                s_b_valid_o,
  input  logic                                s_b_ready_i,
  input  logic [axi_cfg_pkg::IdWidth-1:0]     s_ar_id_i,
  input  logic [axi_cfg_pkg::AddrWidth-1:0]   s_ar_addr_i,
  input  logic [axi_proto_pkg::LenWidth-1:0]  s_ar_len_i,
  input  logic [1:0]                          s_ar_burst_i,
  input  logic                                s_ar_valid_i,
  output logic                                s_ar_ready_o,
  output logic [axi_cfg_pkg::IdWidth-1:0]     s_r_id_o,
  output logic [axi_cfg_pkg::DataWidth-1:0]   s_r_data_o,
  output logic [1:0]                          s_r_resp_o,
  output logic                                s_r_last_o,
  output logic                                s_r_valid_o,
  input  logic                                s_r_ready_i
);

  typedef logic [axi_cfg_pkg::AddrWidth-1:0]         addr_t;
  typedef logic [$clog2(axi_cfg_pkg::MemWords)-1:0]  idx_t;
  typedef logic [axi_proto_pkg::LenWidth-1:0]        len_t;
  typedef enum logic [1:0] {WrIdle, WrData, WrResp} wr_state_e;
  typedef enum logic {RdIdle, RdData} rd_state_e;

  logic [axi_cfg_pkg::DataWidth-1:0] mem_q [axi_cfg_pkg::MemWords];

  wr_state_e                         wr_state_q;
  rd_state_e                         rd_state_q;
  logic [axi_cfg_pkg::IdWidth-1:0]   wr_id_q, rd_id_q;
  addr_t                             wr_addr_q, rd_addr_q;
  len_t                              wr_len_q, rd_len_q, wr_cnt_q, rd_cnt_q;
  axi_proto_pkg::burst_e             wr_burst_q, rd_burst_q;
  axi_proto_pkg::resp_e              wr_worst_q, wr_beat_resp, rd_beat_resp;
  logic                              aw_hs, w_hs, b_hs, ar_hs, r_hs;

  // WRAP is refused as a whole, then the range decides
  function automatic axi_proto_pkg::resp_e beat_resp(addr_t addr,
                                                     axi_proto_pkg::burst_e burst);
    if (burst == axi_proto_pkg::BurstWrap) return axi_proto_pkg::RespSlverr;
    if (addr >= addr_t'(axi_cfg_pkg::MemWords * axi_cfg_pkg::StrbWidth)) begin
      return axi_proto_pkg::RespDecerr;
    end
    return axi_proto_pkg::RespOkay;
  endfunction

  function automatic addr_t next_addr(addr_t addr, axi_proto_pkg::burst_e burst);
    return (burst == axi_proto_pkg::BurstFixed) ? addr : addr + addr_t'(axi_cfg_pkg::StrbWidth);
  endfunction

  function automatic idx_t word_idx(addr_t addr);
    return idx_t'(addr >> $clog2(axi_cfg_pkg::StrbWidth));
  endfunction

  assign s_aw_ready_o = (wr_state_q == WrIdle);
  assign s_w_ready_o  = (wr_state_q == WrData);
  assign s_b_valid_o  = (wr_state_q == WrResp);
  assign s_b_id_o     = wr_id_q;
  assign s_b_resp_o   = wr_worst_q;
  assign aw_hs        = s_aw_valid_i && s_aw_ready_o;
  assign w_hs         = s_w_valid_i && s_w_ready_o;
  assign b_hs         = s_b_valid_o && s_b_ready_i;
  assign wr_beat_resp = beat_resp(wr_addr_q, wr_burst_q);

  // Write FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_state_q <= WrIdle;
      wr_cnt_q   <= '0;
      wr_worst_q <= axi_proto_pkg::RespOkay;
    end else begin
      case (wr_state_q)
        WrIdle: begin
          if (aw_hs) begin
            wr_state_q <= WrData;
            wr_cnt_q   <= '0;
            wr_worst_q <= axi_proto_pkg::RespOkay;
          end
        end
        WrData: begin
          if (w_hs) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
            // B reports the worst beat
            if (wr_beat_resp > wr_worst_q) begin
              wr_worst_q <= wr_beat_resp;
            end
            if (s_w_last_i) begin
              wr_state_q <= WrResp;
            end
          end
        end
        WrResp: begin
          if (b_hs) begin
            wr_state_q <= WrIdle;
          end
        end
        default: wr_state_q <= WrIdle;
      endcase
    end
  end

  // Write burst context and memory array
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_id_q    <= s_aw_id_i;
      wr_addr_q  <= s_aw_addr_i;
      wr_len_q   <= s_aw_len_i;
      wr_burst_q <= axi_proto_pkg::burst_e'(s_aw_burst_i);
    end else if (w_hs) begin
      wr_addr_q  <= next_addr(wr_addr_q, wr_burst_q);
    end
    if (w_hs && wr_beat_resp == axi_proto_pkg::RespOkay) begin
      for (int b = 0; b < axi_cfg_pkg::StrbWidth; b++) begin
        if (s_w_strb_i[b]) begin
          mem_q[word_idx(wr_addr_q)][8*b +: 8] <= s_w_data_i[8*b +: 8];
        end
      end
    end
  end

  assign s_ar_ready_o = (rd_state_q == RdIdle);
  assign s_r_valid_o  = (rd_state_q == RdData);
  assign s_r_id_o     = rd_id_q;
  assign s_r_last_o   = (rd_cnt_q == rd_len_q);
  assign rd_beat_resp = beat_resp(rd_addr_q, rd_burst_q);
  assign s_r_resp_o   = rd_beat_resp;
  // Error beats return zero
  assign s_r_data_o   = (rd_beat_resp == axi_proto_pkg::RespOkay) ?
                        mem_q[word_idx(rd_addr_q)] : '0;
  assign ar_hs        = s_ar_valid_i && s_ar_ready_o;
  assign r_hs         = s_r_valid_o && s_r_ready_i;

  // Read FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_state_q <= RdIdle;
      rd_cnt_q   <= '0;
    end else if (ar_hs) begin
      rd_state_q <= RdData;
      rd_cnt_q   <= '0;
    end else if (r_hs) begin
      rd_cnt_q <= rd_cnt_q + 1'b1;
      if (s_r_last_o) begin
        rd_state_q <= RdIdle;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rd_id_q    <= s_ar_id_i;
      rd_addr_q  <= s_ar_addr_i;
      rd_len_q   <= s_ar_len_i;
      rd_burst_q <= axi_proto_pkg::burst_e'(s_ar_burst_i);
    end else if (r_hs) begin
      rd_addr_q  <= next_addr(rd_addr_q, rd_burst_q);
    end
  end

  // W beat count must agree with the length taken from AW
  assert property (@(posedge clk_i) disable iff (rst_i)
    w_hs |-> (s_w_last_i == (wr_cnt_q == wr_len_q)))
    else $error("axi_mem_slave: w_last does not match AW length");

endmodule

//--- axi_proto_pkg.sv
// #####################################################################
// AXI4 protocol encodings
//   LenWidth  burst length field width
//   burst_e   burst type (FIXED, INCR, WRAP)
//   resp_e    response code (OKAY, EXOKAY, SLVERR, DECERR)
// #####################################################################

package axi_proto_pkg;

  localparam int LenWidth = 8;

  // AxBURST encoding
  typedef enum logic [1:0] {
    BurstFixed = 2'b00,
    BurstIncr  = 2'b01,
    BurstWrap  = 2'b10
  } burst_e;

  // xRESP encoding, numerically ordered by severity
  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespExokay = 2'b01,
    RespSlverr = 2'b10,
    RespDecerr = 2'b11
  } resp_e;

endpackage

//--- flist.f
axi_proto_pkg.sv
axi_cfg_pkg.sv
spill_register.sv
axi_cut.sv
axi_mem_slave.sv
axi_cut_mem_top.sv
tb_axi_cut_mem.sv

//--- spill_register.sv
// #####################################################################
// Two-entry spill register for one valid/ready channel
//   Cuts valid, ready and data paths, one cycle of latency
//   Optional bypass turns it into plain wires
// #####################################################################

module spill_register #(
  parameter int Width  = 8,
  parameter bit Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic             a_full_q;
    logic             b_full_q;
    logic [Width-1:0] a_data_q;
    logic [Width-1:0] b_data_q;
    logic             a_fill;
    logic             a_drain;
    logic             b_fill;
    logic             b_drain;

    // A takes new items, B holds the older one
    assign a_fill  = valid_i && ready_o;
    // A moves on whenever B is empty, out directly if downstream is ready
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Ready from own state only, so no path from ready_i
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    // Stalled output holds its payload, also across the A to B move
    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> $stable(data_o))
      else $error("spill_register: data_o changed while stalled");
  end

endmodule

//--- tb_axi_cut_mem.sv
// #####################################################################
// Directed testbench for the AXI4 register cut with memory slave
//   Clock, reset and cycle timeout
//   AXI write and read driver tasks with optional ready stalls
//   Reference memory model with the response rules
//   Directed tests for bursts, back-pressure and error responses
// #####################################################################

module tb_axi_cut_mem;
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [axi_cfg_pkg::AddrWidth-1:0]    addr_t;
  typedef logic [axi_proto_pkg::LenWidth-1:0]   len_t;
  typedef logic [axi_cfg_pkg::IdWidth-1:0]      id_t;

  // About 20 bursts of up to 8 beats, each beat at most a few cycles when
  // ready stalls, well below 1000 cycles in total
  localparam int TimeoutCycles = 4000;

  logic                                clk_i = 1'b0;
  logic                                rst_i;
  id_t                                 s_aw_id_i, s_ar_id_i, s_b_id_o, s_r_id_o;
  addr_t                               s_aw_addr_i, s_ar_addr_i;
  len_t                                s_aw_len_i, s_ar_len_i;
  logic [1:0]                          s_aw_burst_i, s_ar_burst_i, s_b_resp_o, s_r_resp_o;
  logic [axi_cfg_pkg::DataWidth-1:0]   s_w_data_i, s_r_data_o;
  logic [axi_cfg_pkg::StrbWidth-1:0]   s_w_strb_i;
  logic                                s_w_last_i, s_r_last_o;
  logic                                s_aw_valid_i, s_w_valid_i, s_ar_valid_i;
  logic                                s_aw_ready_o, s_w_ready_o, s_ar_ready_o;
  logic                                s_b_valid_o, s_r_valid_o, s_b_ready_i, s_r_ready_i;

  logic [axi_cfg_pkg::DataWidth-1:0]   ref_mem [axi_cfg_pkg::MemWords];
  integer                              seed = 32'hf7a28642;
  bit                                  stall_en = 1'b0;
  int                                  cycle_cnt = 0;

  axi_cut_mem_top #(.Bypass(1'b0)) u_dut (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Finished with errors");
      $fatal(1, "Timeout: the run hung and did not finish within %0d cycles", TimeoutCycles);
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // Response of one beat by the memory rules
  function automatic logic [1:0] expect_resp(addr_t addr, logic [1:0] burst);
    logic [1:0] resp;
    resp = axi_proto_pkg::RespOkay;
    // Memory ends at byte address 1023
    if (addr > 16'd1023) begin
      resp = axi_proto_pkg::RespDecerr;
    end
    if (burst == axi_proto_pkg::BurstWrap) begin
      resp = axi_proto_pkg::RespSlverr;
    end
    return resp;
  endfunction

  function automatic addr_t step_addr(addr_t addr, logic [1:0] burst);
    return (burst == axi_proto_pkg::BurstFixed) ? addr : addr + addr_t'(4);
  endfunction

  task automatic axi_write(input id_t id, input addr_t addr, input int beats,
                           input logic [1:0] burst, input bit rand_strb);
    addr_t       a;
    logic [1:0]  resp;
    logic [1:0]  worst;
    logic [31:0] data;
    logic [31:0] rnd;
    logic [3:0]  strb;
    bit          done;
    a     = addr;
    worst = axi_proto_pkg::RespOkay;
    @(posedge clk_i);
    s_aw_id_i    <= id;
    s_aw_addr_i  <= addr;
    s_aw_len_i   <= len_t'(beats - 1);
    s_aw_burst_i <= burst;
    s_aw_valid_i <= 1'b1;
    do @(negedge clk_i); while (!s_aw_ready_o);
    @(posedge clk_i);
    s_aw_valid_i <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      data = $random(seed);
      rnd  = $random(seed);
      strb = rand_strb ? rnd[3:0] : 4'hf;
      s_w_data_i  <= data;
      s_w_strb_i  <= strb;
      s_w_last_i  <= (i == beats - 1);
      s_w_valid_i <= 1'b1;
      do @(negedge clk_i); while (!s_w_ready_o);
      @(posedge clk_i);
      // Model takes the beat as it is accepted
      resp = expect_resp(a, burst);
      if (resp > worst) worst = resp;
      if (resp == axi_proto_pkg::RespOkay) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) ref_mem[a[9:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
      a = step_addr(a, burst);
    end
    s_w_valid_i <= 1'b0;
    s_w_last_i  <= 1'b0;
    done = 1'b0;
    while (!done) begin
      rnd = $random(seed);
      s_b_ready_i <= stall_en ? rnd[0] : 1'b1;
      @(negedge clk_i);
      done = s_b_valid_o && s_b_ready_i;
      if (!done) @(posedge clk_i);
    end
    check_eq("s_b_id_o", 32'(s_b_id_o), 32'(id));
    check_eq("s_b_resp_o", 32'(s_b_resp_o), 32'(worst));
    @(posedge clk_i);
    s_b_ready_i <= 1'b0;
    // Exactly one response per burst
    @(negedge clk_i);
    check_eq("s_b_valid_o", 32'(s_b_valid_o), 32'd0);
  endtask

  task automatic axi_read(input id_t id, input addr_t addr, input int beats,
                          input logic [1:0] burst);
    addr_t       a;
    logic [1:0]  resp;
    logic [31:0] exp_data;
    logic [31:0] rnd;
    bit          done;
    a = addr;
    @(posedge clk_i);
    s_ar_id_i    <= id;
    s_ar_addr_i  <= addr;
    s_ar_len_i   <= len_t'(beats - 1);
    s_ar_burst_i <= burst;
    s_ar_valid_i <= 1'b1;
    do @(negedge clk_i); while (!s_ar_ready_o);
    @(posedge clk_i);
    s_ar_valid_i <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      done = 1'b0;
      while (!done) begin
        rnd = $random(seed);
        s_r_ready_i <= stall_en ? rnd[0] : 1'b1;
        @(negedge clk_i);
        done = s_r_valid_o && s_r_ready_i;
        if (!done) @(posedge clk_i);
      end
      resp     = expect_resp(a, burst);
      exp_data = (resp == axi_proto_pkg::RespOkay) ? ref_mem[a[9:2]] : 32'd0;
      check_eq("s_r_id_o", 32'(s_r_id_o), 32'(id));
      check_eq("s_r_data_o", s_r_data_o, exp_data);
      check_eq("s_r_resp_o", 32'(s_r_resp_o), 32'(resp));
      check_eq("s_r_last_o", 32'(s_r_last_o), 32'(i == beats - 1));
      @(posedge clk_i);
      a = step_addr(a, burst);
    end
    s_r_ready_i <= 1'b0;
    @(negedge clk_i);
    check_eq("s_r_valid_o", 32'(s_r_valid_o), 32'd0);
  endtask

  // Valids stay low through reset and the first cycle after it
  task automatic reset_outputs_low();
    repeat (4) begin
      @(negedge clk_i);
      check_eq("s_b_valid_o", 32'(s_b_valid_o), 32'd0);
      check_eq("s_r_valid_o", 32'(s_r_valid_o), 32'd0);
    end
    @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      check_eq("s_b_valid_o", 32'(s_b_valid_o), 32'd0);
      check_eq("s_r_valid_o", 32'(s_r_valid_o), 32'd0);
      @(posedge clk_i);
    end
  endtask

  task automatic single_beat();
    axi_write(4'h3, 16'h0010, 1, axi_proto_pkg::BurstIncr, 1'b0);
    axi_read(4'h5, 16'h0010, 1, axi_proto_pkg::BurstIncr);
  endtask

  task automatic incr_burst();
    axi_write(4'h1, 16'h0100, 8, axi_proto_pkg::BurstIncr, 1'b0);
    axi_write(4'h2, 16'h0100, 8, axi_proto_pkg::BurstIncr, 1'b1);
    axi_read(4'h3, 16'h0100, 8, axi_proto_pkg::BurstIncr);
  endtask

  task automatic fixed_burst();
    axi_write(4'h4, 16'h0200, 1, axi_proto_pkg::BurstIncr, 1'b0);
    axi_write(4'h5, 16'h0200, 4, axi_proto_pkg::BurstFixed, 1'b1);
    axi_read(4'h6, 16'h0200, 4, axi_proto_pkg::BurstFixed);
  endtask

  task automatic ready_stalls();
    stall_en = 1'b1;
    axi_write(4'h7, 16'h0300, 8, axi_proto_pkg::BurstIncr, 1'b0);
    axi_write(4'h8, 16'h0300, 8, axi_proto_pkg::BurstIncr, 1'b1);
    axi_read(4'h9, 16'h0300, 8, axi_proto_pkg::BurstIncr);
    axi_read(4'ha, 16'h0200, 4, axi_proto_pkg::BurstFixed);
    axi_read(4'hb, 16'h0100, 8, axi_proto_pkg::BurstIncr);
    stall_en = 1'b0;
  endtask

  task automatic error_responses();
    // Last two beats fall past the end of the memory
    axi_write(4'hc, 16'h03f8, 4, axi_proto_pkg::BurstIncr, 1'b0);
    axi_read(4'hd, 16'h03f8, 4, axi_proto_pkg::BurstIncr);
    axi_write(4'he, 16'h0100, 4, axi_proto_pkg::BurstWrap, 1'b0);
    axi_read(4'hf, 16'h0100, 8, axi_proto_pkg::BurstIncr);
    axi_read(4'h1, 16'h0100, 4, axi_proto_pkg::BurstWrap);
  endtask

  initial begin
    rst_i        <= 1'b1;
    s_aw_id_i    <= '0;
    s_aw_addr_i  <= '0;
    s_aw_len_i   <= '0;
    s_aw_burst_i <= '0;
    s_aw_valid_i <= 1'b0;
    s_w_data_i   <= '0;
    s_w_strb_i   <= '0;
    s_w_last_i   <= 1'b0;
    s_w_valid_i  <= 1'b0;
    s_b_ready_i  <= 1'b0;
    s_ar_id_i    <= '0;
    s_ar_addr_i  <= '0;
    s_ar_len_i   <= '0;
    s_ar_burst_i <= '0;
    s_ar_valid_i <= 1'b0;
    s_r_ready_i  <= 1'b0;
    reset_outputs_low();
    single_beat();
    incr_burst();
    fixed_burst();
    ready_stalls();
    error_responses();
    repeat (4) @(posedge clk_i);
    $display("Finished with no errors");
    $finish;
  end

endmodule
